/* bench/loader_tb.sv */
// Loader testbench: erase, ROM upload, back-pressure, loaded flags and mouse axis checks

`timescale 1ns/1ps

module loader_tb;
	import loader_pkg::*;

	localparam int ERASE_WORDS = 64;
	localparam int NUM_BEATS   = 100;
	localparam int MAX_STALL   = 4;
	localparam int MOUSE_TICKS = 100;
	localparam int CLK_PERIOD  = 100;
	// Each erase word or beat may sit out a full stall, doubled for margin
	localparam int WATCHDOG_NS = ((ERASE_WORDS + NUM_BEATS) * (MAX_STALL + 3) +
	                              MOUSE_TICKS + 20) * CLK_PERIOD * 2;

	logic                  clk_sys = 1'b0;
	logic                  areset;
	logic                  mem_init_done_i;
	logic                  boot_rom_en_i;
	logic                  dl_valid_i;
	logic [7:0]            dl_index_i;
	logic [DL_ADDR_W-1:0]  dl_addr_i;
	logic [7:0]            dl_data_i;
	logic                  dl_ready_o;
	logic                  mem_valid_o;
	logic [MEM_ADDR_W-1:0] mem_addr_o;
	logic [7:0]            mem_data_o;
	logic                  mem_ready_i;
	logic                  pbi_loaded_o;
	logic                  freezer_loaded_o;
	logic                  mouse_stb_i;
	logic signed [8:0]     mouse_dx_i;
	logic signed [8:0]     mouse_dy_i;
	logic [1:0]            mouse_btn_i;
	logic                  invert_x_i;
	logic                  invert_y_i;
	logic                  halt_i;
	logic signed [7:0]     stick_x_i;
	logic signed [7:0]     stick_y_i;
	logic [1:0]            stick_btn_i;
	logic signed [7:0]     axis_x_o;
	logic signed [7:0]     axis_y_o;
	logic [1:0]            fire_o;
	logic                  mouse_active_o;

	integer seed;
	int     errors = 0;
	int     tests = 0;
	int     err_mark = 0;
	int     stall_cnt = 0;
	int     hold_off = 0;
	int     rd_idx = 0;
	int     wr_idx = 0;

	// Expected memory writes in order, erase words first
	logic [MEM_ADDR_W-1:0] exp_addr [ERASE_WORDS + NUM_BEATS];
	logic [7:0]            exp_data [ERASE_WORDS + NUM_BEATS];

	// Mouse reference state
	logic              m_active = 1'b0;
	logic signed [7:0] m_x = '0;
	logic signed [7:0] m_y = '0;

	logic [7:0] rom_codes [12] = '{8'h00, 8'h40, 8'h80, 8'hC0, 8'h03, 8'h04,
	                               8'h05, 8'h06, 8'h43, 8'h84, 8'hC5, 8'h46};
	logic [7:0] junk_codes [4] = '{8'h01, 8'h07, 8'h3F, 8'h92};

	loader_top #(.erase_words(ERASE_WORDS)) loader_top_i (.*);

	initial begin
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t, the run did not complete", $time);
		$display("Regression failed");
		$finish;
	end

	always @(posedge clk_sys) begin
		if (areset)
			rd_idx <= 0;
		else if (mem_valid_o && mem_ready_i)
			rd_idx <= rd_idx + 1;
	end

	// ======================================================================
	// Reference rules
	// ======================================================================

	// Region decode by priority XL, OS-A/B, BASIC, PBI, TurboFreezer
	function automatic logic map_index(input logic [7:0] idx, input logic en,
		input logic [15:0] a, output logic [MEM_ADDR_W-1:0] ma);
		logic [5:0] lo;
		lo = idx[5:0];
		map_index = 1'b1;
		if ((en && idx == BOOT_XL) || lo == IDX_XL)
			ma = (XL_OS_BASE & ~23'h3FFF) | 23'(a[13:0]);
		else if ((en && idx == BOOT_OSAB) || lo == IDX_OSAB)
			ma = ((OSAB_BASE & ~23'h3FFF) | 23'(a[13:0])) + 23'(OSAB_SKEW);
		else if ((en && idx == BOOT_BASIC) || lo == IDX_BASIC)
			ma = (BASIC_BASE & ~23'h1FFF) | 23'(a[12:0]);
		else if (idx == BOOT_PBI)
			ma = (PBI_BASE & ~23'h1FFF) | 23'(a[12:0]);
		else if (lo == IDX_FREEZER)
			ma = (FREEZER_BASE & ~23'hFFFF) | 23'(a);
		else begin
			map_index = 1'b0;
			ma = '0;
		end
	endfunction

	function automatic int axis_step(input int pos, input int delta, input logic inv);
		int d;
		int p;
		d = delta;
		if (d > int'(MOUSE_STEP_MAX))
			d = int'(MOUSE_STEP_MAX);
		if (d < -int'(MOUSE_STEP_MAX))
			d = -int'(MOUSE_STEP_MAX);
		p = inv ? pos - d : pos + d;
		if (p > int'(AXIS_MAX))
			p = int'(AXIS_MAX);
		if (p < int'(AXIS_MIN))
			p = int'(AXIS_MIN);
		return p;
	endfunction

	// ======================================================================
	// Checks
	// ======================================================================

	a_reset_state: assert property (@(posedge clk_sys) $fell(areset) |->
		!mem_valid_o && !dl_ready_o && !pbi_loaded_o && !freezer_loaded_o &&
		!mouse_active_o && axis_x_o == 8'sd0 && axis_y_o == 8'sd0)
		else begin
			$display("ERR @%0t: outputs not cleared by reset", $time);
			errors++;
		end

	a_write_due: assert property (@(posedge clk_sys) disable iff (areset)
		mem_valid_o && mem_ready_i |-> rd_idx < wr_idx)
		else begin
			$display("ERR @%0t: unexpected memory write to %h", $time, mem_addr_o);
			errors++;
		end

	a_write_value: assert property (@(posedge clk_sys) disable iff (areset)
		mem_valid_o && mem_ready_i && rd_idx < wr_idx |->
		mem_addr_o == exp_addr[rd_idx] && mem_data_o == exp_data[rd_idx])
		else begin
			$display("ERR @%0t: write %0d got %h/%h, expected %h/%h", $time, rd_idx,
			         mem_addr_o, mem_data_o, exp_addr[rd_idx], exp_data[rd_idx]);
			errors++;
		end

	a_erase_first: assert property (@(posedge clk_sys) disable iff (areset)
		dl_ready_o |-> rd_idx >= ERASE_WORDS)
		else begin
			$display("ERR @%0t: download accepted before erase finished", $time);
			errors++;
		end

	a_init_idle: assert property (@(posedge clk_sys) disable iff (areset)
		!mem_init_done_i |-> !mem_valid_o)
		else begin
			$display("ERR @%0t: memory write before init done", $time);
			errors++;
		end

	a_stall_hold: assert property (@(posedge clk_sys) disable iff (areset)
		mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o) &&
		$stable(mem_data_o))
		else begin
			$display("ERR @%0t: memory request changed while stalled", $time);
			errors++;
		end

	a_stall_ready: assert property (@(posedge clk_sys) disable iff (areset)
		mem_valid_o && !mem_ready_i |-> !dl_ready_o)
		else begin
			$display("ERR @%0t: host not held off under back-pressure", $time);
			errors++;
		end

	a_pbi_rise: assert property (@(posedge clk_sys) disable iff (areset)
		$rose(pbi_loaded_o) |-> $past(dl_valid_i && dl_ready_o && dl_index_i == BOOT_PBI))
		else begin
			$display("ERR @%0t: PBI flag set without a PBI beat", $time);
			errors++;
		end

	a_frz_rise: assert property (@(posedge clk_sys) disable iff (areset)
		$rose(freezer_loaded_o) |->
		$past(dl_valid_i && dl_ready_o && dl_index_i[5:0] == IDX_FREEZER))
		else begin
			$display("ERR @%0t: TurboFreezer flag set without a matching beat", $time);
			errors++;
		end

	a_flags_sticky: assert property (@(posedge clk_sys) disable iff (areset)
		pbi_loaded_o || freezer_loaded_o |=>
		pbi_loaded_o >= $past(pbi_loaded_o) && freezer_loaded_o >= $past(freezer_loaded_o))
		else begin
			$display("ERR @%0t: loaded flag dropped", $time);
			errors++;
		end

	// Outputs settle after the rising edge, so the mouse is checked on the falling one
	a_mouse: assert property (@(negedge clk_sys) disable iff (areset)
		mouse_active_o == m_active &&
		axis_x_o == (m_active ? m_x : stick_x_i) &&
		axis_y_o == (m_active ? m_y : stick_y_i) &&
		fire_o == (m_active ? mouse_btn_i : stick_btn_i))
		else begin
			$display("ERR @%0t: mouse got %0d/%0d act %b, expected %0d/%0d act %b", $time,
			         axis_x_o, axis_y_o, mouse_active_o, m_x, m_y, m_active);
			errors++;
		end

	// ======================================================================
	// Stimulus
	// ======================================================================

	// Next falling edge, with a random memory stall of bounded length
	task automatic tick();
		@(negedge clk_sys);
		if (hold_off > 0) begin
			mem_ready_i = 1'b0;
			hold_off--;
			stall_cnt = MAX_STALL;
		end else if (stall_cnt < MAX_STALL && $random(seed) % 2 != 0) begin
			mem_ready_i = 1'b0;
			stall_cnt++;
		end else begin
			mem_ready_i = 1'b1;
			stall_cnt = 0;
		end
	endtask

	task automatic send_beat(input logic [7:0] idx, input logic en);
		logic [MEM_ADDR_W-1:0] ma;
		boot_rom_en_i = en;
		dl_index_i = idx;
		dl_addr_i = 16'($random(seed));
		dl_data_i = 8'($random(seed));
		dl_valid_i = 1'b1;
		while (!dl_ready_o)
			tick();
		// Ready is seen before the edge, so the beat transfers on the next one
		if (map_index(idx, en, dl_addr_i, ma)) begin
			exp_addr[wr_idx] = ma;
			exp_data[wr_idx] = dl_data_i;
			wr_idx++;
		end
		tick();
		dl_valid_i = 1'b0;
	endtask

	task automatic mouse_report(input int dx, input int dy);
		mouse_dx_i = 9'(dx);
		mouse_dy_i = 9'(dy);
		mouse_btn_i = 2'($random(seed));
		stick_btn_i = 2'($random(seed));
		mouse_stb_i = ~mouse_stb_i;
		if (stick_x_i != 8'sd0 || stick_y_i != 8'sd0 || halt_i) begin
			m_active = 1'b0;
			m_x = '0;
			m_y = '0;
		end else begin
			m_active = 1'b1;
			m_x = 8'(axis_step(int'(m_x), dx, invert_x_i));
			m_y = 8'(axis_step(int'(m_y), dy, invert_y_i));
		end
		tick();
	endtask

	task automatic set_stick(input logic signed [7:0] sx, input logic signed [7:0] sy,
		input logic h);
		stick_x_i = sx;
		stick_y_i = sy;
		halt_i = h;
		stick_btn_i = 2'($random(seed));
		if (sx != 8'sd0 || sy != 8'sd0 || h) begin
			m_active = 1'b0;
			m_x = '0;
			m_y = '0;
		end
		tick();
	endtask

	task automatic end_test(input string name);
		$display("[%0t] test %s done, %0d error(s)", $time, name, errors - err_mark);
		err_mark = errors;
		tests++;
	endtask

	initial begin
		seed = 32'h91ff85cd;
		areset = 1'b1;
		mem_init_done_i = 1'b0;
		boot_rom_en_i = 1'b0;
		dl_valid_i = 1'b0;
		dl_index_i = '0;
		dl_addr_i = '0;
		dl_data_i = '0;
		mem_ready_i = 1'b1;
		mouse_stb_i = 1'b0;
		mouse_dx_i = '0;
		mouse_dy_i = '0;
		mouse_btn_i = '0;
		invert_x_i = 1'b0;
		invert_y_i = 1'b0;
		halt_i = 1'b0;
		stick_x_i = '0;
		stick_y_i = '0;
		stick_btn_i = '0;
		for (int i = 0; i < ERASE_WORDS; i++) begin
			exp_addr[i] = ERASE_BASE + 23'(i);
			exp_data[i] = FILL_BYTE;
		end
		wr_idx = ERASE_WORDS;
		repeat (2) tick();
		areset = 1'b0;

		// Memory still initialising, then a junk beat waits out the erase
		repeat (4) tick();
		mem_init_done_i = 1'b1;
		dl_index_i = 8'h01;
		dl_valid_i = 1'b1;
		while (rd_idx < ERASE_WORDS)
			tick();
		tick();
		dl_valid_i = 1'b0;
		end_test("erase");

		for (int rep = 0; rep < 3; rep++)
			for (int k = 0; k < 12; k++)
				for (int en = 0; en < 2; en++)
					send_beat(rom_codes[k], 1'(en));
		end_test("rom_map");

		for (int rep = 0; rep < 3; rep++)
			for (int k = 0; k < 4; k++)
				for (int en = 0; en < 2; en++)
					send_beat(junk_codes[k], 1'(en));
		end_test("discard");

		hold_off = MAX_STALL;
		send_beat(8'h06, 1'b0);
		send_beat(8'hC0, 1'b1);
		while (rd_idx != wr_idx)
			tick();
		end_test("backpressure");

		assert (pbi_loaded_o && freezer_loaded_o)
		else begin
			$display("ERR @%0t: loaded flags not both set after upload", $time);
			errors++;
		end
		end_test("loaded_flags");

		// Inactive pass-through, then runs to both clamp limits
		repeat (6) set_stick(8'($random(seed)), 8'($random(seed)), 1'b0);
		set_stick(8'sd0, 8'sd0, 1'b0);
		invert_y_i = 1'b1;
		repeat (20) mouse_report(15 + ($random(seed) & 15), 15 + ($random(seed) & 15));
		repeat (30) begin
			invert_x_i = 1'($random(seed));
			invert_y_i = 1'($random(seed));
			mouse_report($random(seed) % 40, $random(seed) % 40);
		end
		set_stick(8'sd0, 8'sd0, 1'b1);
		set_stick(8'sd0, 8'sd0, 1'b0);
		repeat (3) mouse_report($random(seed) % 40, $random(seed) % 40);
		set_stick(8'sd5, 8'sd0, 1'b0);
		repeat (2) mouse_report($random(seed) % 40, $random(seed) % 40);
		set_stick(8'sd0, 8'sd0, 1'b0);
		tick();
		end_test("mouse");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* common/loader_pkg.sv */
// Loader package with the memory map, download index codes and mouse limits

package loader_pkg;

	// ======================================================================
	// Address widths
	// ======================================================================

	localparam int MEM_ADDR_W = 23;
	localparam int DL_ADDR_W  = 16;

	// ======================================================================
	// Memory map
	// ======================================================================

	// Start of the block filled with FILL_BYTE after memory init
	localparam logic [MEM_ADDR_W-1:0] ERASE_BASE = 23'h70_0000;

	// System ROM regions, low address bits come from the download address
	localparam logic [MEM_ADDR_W-1:0] XL_OS_BASE   = 23'h70_4000;
	localparam logic [MEM_ADDR_W-1:0] OSAB_BASE    = 23'h70_8000;
	localparam logic [MEM_ADDR_W-1:0] BASIC_BASE   = 23'h70_0000;
	localparam logic [MEM_ADDR_W-1:0] PBI_BASE     = 23'h70_2000;
	localparam logic [MEM_ADDR_W-1:0] FREEZER_BASE = 23'h4A_0000;

	// OS-A/B image sits above the unused low part of its 16K slot
	localparam logic [13:0] OSAB_SKEW = 14'h1800;

	// ======================================================================
	// Download index codes
	// ======================================================================

	// Menu file slots, matched on the low six index bits
	localparam logic [5:0] IDX_FREEZER = 6'd3;
	localparam logic [5:0] IDX_XL      = 6'd4;
	localparam logic [5:0] IDX_BASIC   = 6'd5;
	localparam logic [5:0] IDX_OSAB    = 6'd6;

	// Boot files, matched on the full index
	localparam logic [7:0] BOOT_XL    = 8'h00;
	localparam logic [7:0] BOOT_BASIC = 8'h40;
	localparam logic [7:0] BOOT_OSAB  = 8'h80;
	localparam logic [7:0] BOOT_PBI   = 8'hC0;

	localparam logic [7:0] FILL_BYTE = 8'hFF;

	// ======================================================================
	// Mouse to analog axis
	// ======================================================================

	localparam logic signed [8:0] MOUSE_STEP_MAX = 9'sd10;
	localparam logic signed [8:0] AXIS_MIN       = -9'sd128;
	localparam logic signed [8:0] AXIS_MAX       = 9'sd127;

endpackage

/* files.f */
common/loader_pkg.sv
rtl/rom_loader/rom_addr_map.sv
rtl/rom_loader/mem_eraser.sv
rtl/rom_loader/upload_arbiter.sv
rtl/mouse_axis.sv
rtl/loader_top.sv
bench/loader_tb.sv

/* rtl/loader_top.sv */
// Loader top: memory erase, system ROM upload and mouse analog axis

`timescale 1ns/1ps

module loader_top #(
	parameter int erase_words = 65536
) (
	input  logic                               clk_sys,
	input  logic                               areset,
	input  logic                               mem_init_done_i,
	input  logic                               boot_rom_en_i,
	// Host download stream
	input  logic                               dl_valid_i,
	input  logic [7:0]                         dl_index_i,
	input  logic [loader_pkg::DL_ADDR_W-1:0]   dl_addr_i,
	input  logic [7:0]                         dl_data_i,
	output logic                               dl_ready_o,
	// Memory write port
	output logic                               mem_valid_o,
	output logic [loader_pkg::MEM_ADDR_W-1:0]  mem_addr_o,
	output logic [7:0]                         mem_data_o,
	input  logic                               mem_ready_i,
	output logic                               pbi_loaded_o,
	output logic                               freezer_loaded_o,
	// Mouse and stick
	input  logic                               mouse_stb_i,
	input  logic signed [8:0]                  mouse_dx_i,
	input  logic signed [8:0]                  mouse_dy_i,
	input  logic [1:0]                         mouse_btn_i,
	input  logic                               invert_x_i,
	input  logic                               invert_y_i,
	input  logic                               halt_i,
	input  logic signed [7:0]                  stick_x_i,
	input  logic signed [7:0]                  stick_y_i,
	input  logic [1:0]                         stick_btn_i,
	output logic signed [7:0]                  axis_x_o,
	output logic signed [7:0]                  axis_y_o,
	output logic [1:0]                         fire_o,
	output logic                               mouse_active_o
);
	import loader_pkg::*;

	logic                  erase_valid;
	logic                  erase_done;
	logic                  erase_accept;
	logic [MEM_ADDR_W-1:0] erase_addr;
	logic                  rom_hit;
	logic [MEM_ADDR_W-1:0] rom_addr;

	// ======================================================================
	// ROM loader
	// ======================================================================

	rom_addr_map rom_addr_map_i (
		.clk_sys, .areset, .boot_rom_en_i, .dl_valid_i,
		.dl_ready_i(dl_ready_o), .dl_index_i, .dl_addr_i,
		.rom_hit_o(rom_hit), .rom_addr_o(rom_addr),
		.pbi_loaded_o, .freezer_loaded_o
	);

	mem_eraser #(.erase_words(erase_words)) mem_eraser_i (
		.clk_sys, .areset, .mem_init_done_i,
		.erase_accept_i(erase_accept), .erase_valid_o(erase_valid),
		.erase_done_o(erase_done), .erase_addr_o(erase_addr)
	);

	upload_arbiter upload_arbiter_i (
		.clk_sys, .areset,
		.erase_valid_i(erase_valid), .erase_done_i(erase_done),
		.erase_addr_i(erase_addr), .rom_addr_i(rom_addr), .rom_hit_i(rom_hit),
		.dl_valid_i, .dl_data_i, .erase_accept_o(erase_accept), .dl_ready_o,
		.mem_valid_o, .mem_addr_o, .mem_data_o, .mem_ready_i
	);

	// ======================================================================
	// Mouse
	// ======================================================================

	mouse_axis mouse_axis_i (
		.clk_sys, .areset, .mouse_stb_i, .mouse_dx_i, .mouse_dy_i, .mouse_btn_i,
		.invert_x_i, .invert_y_i, .halt_i, .stick_x_i, .stick_y_i, .stick_btn_i,
		.axis_x_o, .axis_y_o, .fire_o, .mouse_active_o
	);

endmodule

/* rtl/mouse_axis.sv */
// Mouse to analog stick: accumulates clamped motion and takes over the fire buttons

`timescale 1ns/1ps

module mouse_axis (
	input  logic              clk_sys,
	input  logic              areset,
	input  logic              mouse_stb_i,
	input  logic signed [8:0] mouse_dx_i,
	input  logic signed [8:0] mouse_dy_i,
	input  logic [1:0]        mouse_btn_i,
	input  logic              invert_x_i,
	input  logic              invert_y_i,
	input  logic              halt_i,
	input  logic signed [7:0] stick_x_i,
	input  logic signed [7:0] stick_y_i,
	input  logic [1:0]        stick_btn_i,
	output logic signed [7:0] axis_x_o,
	output logic signed [7:0] axis_y_o,
	output logic [1:0]        fire_o,
	output logic              mouse_active_o
);
	import loader_pkg::*;

	logic              stb_q;
	logic signed [7:0] pos_x;
	logic signed [7:0] pos_y;
	logic              stick_moved;

	// Limit the step, apply it in the chosen direction, then clamp
	function automatic logic signed [7:0] next_pos(input logic signed [7:0] pos,
		input logic signed [8:0] delta, input logic inv);
		logic signed [8:0] step;
		logic signed [8:0] base;
		logic signed [8:0] sum;
		base = pos;
		if (delta > MOUSE_STEP_MAX)
			step = MOUSE_STEP_MAX;
		else if (delta < -MOUSE_STEP_MAX)
			step = -MOUSE_STEP_MAX;
		else
			step = delta;
		sum = inv ? base - step : base + step;
		if (sum < AXIS_MIN)
			return AXIS_MIN[7:0];
		else if (sum > AXIS_MAX)
			return AXIS_MAX[7:0];
		return sum[7:0];
	endfunction

	assign stick_moved = (stick_x_i != 8'sd0) || (stick_y_i != 8'sd0);

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_q          <= 1'b0;
			mouse_active_o <= 1'b0;
			pos_x          <= '0;
			pos_y          <= '0;
		end else begin
			stb_q <= mouse_stb_i;
			// Real stick input or a halted CPU hands control back
			if (stick_moved || halt_i) begin
				mouse_active_o <= 1'b0;
				pos_x          <= '0;
				pos_y          <= '0;
			end else if (mouse_stb_i != stb_q) begin
				mouse_active_o <= 1'b1;
				pos_x          <= next_pos(pos_x, mouse_dx_i, invert_x_i);
				pos_y          <= next_pos(pos_y, mouse_dy_i, invert_y_i);
			end
		end
	end

	assign axis_x_o = mouse_active_o ? pos_x : stick_x_i;
	assign axis_y_o = mouse_active_o ? pos_y : stick_y_i;
	assign fire_o   = mouse_active_o ? mouse_btn_i : stick_btn_i;

endmodule

/* rtl/rom_loader/mem_eraser.sv */
// Memory eraser: fills the ROM area with FILL_BYTE once memory init is done

`timescale 1ns/1ps

module mem_eraser #(
	parameter int erase_words = 65536
) (
	input  logic                               clk_sys,
	input  logic                               areset,
	input  logic                               mem_init_done_i,
	input  logic                               erase_accept_i,
	output logic                               erase_valid_o,
	output logic                               erase_done_o,
	output logic [loader_pkg::MEM_ADDR_W-1:0]  erase_addr_o
);
	import loader_pkg::*;

	// One bit wider than the block, the top bit marks completion
	logic [$clog2(erase_words):0] erase_cnt;

	// ======================================================================
	// Progress
	// ======================================================================

	assign erase_done_o  = erase_cnt[$clog2(erase_words)];
	assign erase_valid_o = mem_init_done_i & ~erase_done_o;

	// Top bit is clear while the address is in use
	assign erase_addr_o = ERASE_BASE + MEM_ADDR_W'(erase_cnt);

	always_ff @(posedge clk_sys) begin
		if (areset)
			erase_cnt <= '0;
		else if (erase_accept_i && !erase_done_o)
			erase_cnt <= erase_cnt + 1'b1;
	end

endmodule

/* rtl/rom_loader/rom_addr_map.sv */
// ROM address map: decodes the download index into a region and tracks loaded ROMs

`timescale 1ns/1ps

module rom_addr_map (
	input  logic                               clk_sys,
	input  logic                               areset,
	input  logic                               boot_rom_en_i,
	input  logic                               dl_valid_i,
	input  logic                               dl_ready_i,
	input  logic [7:0]                         dl_index_i,
	input  logic [loader_pkg::DL_ADDR_W-1:0]   dl_addr_i,
	output logic                               rom_hit_o,
	output logic [loader_pkg::MEM_ADDR_W-1:0]  rom_addr_o,
	output logic                               pbi_loaded_o,
	output logic                               freezer_loaded_o
);
	import loader_pkg::*;

	logic xl_sel;
	logic osab_sel;
	logic basic_sel;
	logic pbi_sel;
	logic freezer_sel;
	logic beat_xfer;

	// Boot codes only count when boot files are enabled
	assign xl_sel      = (boot_rom_en_i && dl_index_i == BOOT_XL) ||
	                     dl_index_i[5:0] == IDX_XL;
	assign osab_sel    = (boot_rom_en_i && dl_index_i == BOOT_OSAB) ||
	                     dl_index_i[5:0] == IDX_OSAB;
	assign basic_sel   = (boot_rom_en_i && dl_index_i == BOOT_BASIC) ||
	                     dl_index_i[5:0] == IDX_BASIC;
	// No menu slot for PBI
	assign pbi_sel     = dl_index_i == BOOT_PBI;
	assign freezer_sel = dl_index_i[5:0] == IDX_FREEZER;

	assign beat_xfer = dl_valid_i & dl_ready_i;

	// Region priority follows the order of the checks
	always_comb begin
		rom_hit_o = 1'b1;
		if (xl_sel) begin
			rom_addr_o = {XL_OS_BASE[MEM_ADDR_W-1:14], dl_addr_i[13:0]};
		end else if (osab_sel) begin
			rom_addr_o = {OSAB_BASE[MEM_ADDR_W-1:14], dl_addr_i[13:0]} +
			             MEM_ADDR_W'(OSAB_SKEW);
		end else if (basic_sel) begin
			rom_addr_o = {BASIC_BASE[MEM_ADDR_W-1:13], dl_addr_i[12:0]};
		end else if (pbi_sel) begin
			rom_addr_o = {PBI_BASE[MEM_ADDR_W-1:13], dl_addr_i[12:0]};
		end else if (freezer_sel) begin
			// TurboFreezer image spans the full 64K download space
			rom_addr_o = {FREEZER_BASE[MEM_ADDR_W-1:DL_ADDR_W], dl_addr_i};
		end else begin
			rom_hit_o  = 1'b0;
			rom_addr_o = '0;
		end
	end

	// Sticky loaded flags, set on a transferred beat
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			pbi_loaded_o     <= 1'b0;
			freezer_loaded_o <= 1'b0;
		end else if (beat_xfer) begin
			if (pbi_sel)
				pbi_loaded_o <= 1'b1;
			if (freezer_sel)
				freezer_loaded_o <= 1'b1;
		end
	end

endmodule

/* rtl/rom_loader/upload_arbiter.sv */
// Upload arbiter: drives the memory port from the eraser or a one-entry ROM write buffer

`timescale 1ns/1ps

module upload_arbiter (
	input  logic                               clk_sys,
	input  logic                               areset,
	input  logic                               erase_valid_i,
	input  logic                               erase_done_i,
	input  logic [loader_pkg::MEM_ADDR_W-1:0]  erase_addr_i,
	input  logic [loader_pkg::MEM_ADDR_W-1:0]  rom_addr_i,
	input  logic                               rom_hit_i,
	input  logic                               dl_valid_i,
	input  logic [7:0]                         dl_data_i,
	output logic                               erase_accept_o,
	output logic                               dl_ready_o,
	output logic                               mem_valid_o,
	output logic [loader_pkg::MEM_ADDR_W-1:0]  mem_addr_o,
	output logic [7:0]                         mem_data_o,
	input  logic                               mem_ready_i
);
	import loader_pkg::*;

	logic                  hold_valid;
	logic [MEM_ADDR_W-1:0] hold_addr;
	logic [7:0]            hold_data;
	logic                  dl_xfer;

	// Host is held off during erase and while a write is pending
	assign dl_ready_o     = erase_done_i & ~hold_valid;
	assign dl_xfer        = dl_valid_i & dl_ready_o;
	assign erase_accept_o = ~erase_done_i & erase_valid_i & mem_ready_i;

	// ======================================================================
	// Memory port mux
	// ======================================================================

	always_comb begin
		if (!erase_done_i) begin
			mem_valid_o = erase_valid_i;
			mem_addr_o  = erase_addr_i;
			mem_data_o  = FILL_BYTE;
		end else begin
			mem_valid_o = hold_valid;
			mem_addr_o  = hold_addr;
			mem_data_o  = hold_data;
		end
	end

	// Non-ROM beats are accepted here and simply never fill the buffer
	always_ff @(posedge clk_sys) begin
		if (areset)
			hold_valid <= 1'b0;
		else if (dl_xfer && rom_hit_i)
			hold_valid <= 1'b1;
		else if (hold_valid && mem_ready_i)
			hold_valid <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (dl_xfer && rom_hit_i) begin
			hold_addr <= rom_addr_i;
			hold_data <= dl_data_i;
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the loader testbench with Verilator, runs it and scans the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module loader_tb -o loader_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/loader_sim > "$LOG" 2>&1; then
	cat "$LOG"
	echo "Simulation exited with an error"
	exit 1
fi

cat "$LOG"
if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
exit 0
